/* src/apb_subsys_pkg.sv */
package apb_subsys_pkg;

  // ----------------------------------------
  // AHB-lite and APB bus bundles
  // ----------------------------------------
  typedef struct packed {
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;   // IDLE, BUSY, NONSEQ, SEQ
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;   // Valid in the data phase
  } ahb_req_t;

  typedef struct packed {
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;    // OKAY or ERROR only
  } ahb_rsp_t;

  // Shared by every slot
  typedef struct packed {
    logic [31:0] paddr;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;    // Filled in by the decoder
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic       HRESP_OKAY    = 1'b0;
  localparam logic       HRESP_ERROR   = 1'b1;

  // ----------------------------------------
  // Slot map, 64 KB per slot
  // ----------------------------------------
  localparam int          N_SLOTS    = 9;
  localparam int          SLOT_W     = $clog2(N_SLOTS);
  localparam logic [31:0] SLOT_BASE  = 32'h0080_0000;
  localparam int          SLOT_SHIFT = 16;

  localparam logic [SLOT_W-1:0] SLOT_SPI   = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_UART0 = 4'd1;   // Byte wide
  localparam logic [SLOT_W-1:0] SLOT_GPIO  = 4'd2;
  localparam logic [SLOT_W-1:0] SLOT_TTC   = 4'd3;
  localparam logic [SLOT_W-1:0] SLOT_SMC   = 4'd5;
  localparam logic [SLOT_W-1:0] SLOT_PMC   = 4'd6;   // Internal power control
  localparam logic [SLOT_W-1:0] SLOT_UART1 = 4'd8;   // Byte wide

  // Slots 4 and 7 are holes and answer ERROR
  localparam logic [N_SLOTS-1:0] SLOT_USED = 9'b1_0110_1111;

  // Power control registers, word offsets inside the slot
  localparam logic [SLOT_SHIFT-1:0] PMC_CTRL_OFFS = 16'h0000;
  localparam logic [SLOT_SHIFT-1:0] PMC_WAKE_OFFS = 16'h0004;
  localparam int                    CTRL_ISO_BIT  = 8;   // isolate_mem

  // ----------------------------------------
  // Power domains, bit positions in CTRL
  // ----------------------------------------
  localparam int N_DOMAINS = 6;
  localparam int DOM_SMC   = 0;
  localparam int DOM_URT   = 1;
  localparam int DOM_MACB0 = 2;
  localparam int DOM_MACB1 = 3;
  localparam int DOM_MACB2 = 4;
  localparam int DOM_MACB3 = 5;

  typedef struct packed {
    logic       spi;
    logic       uart0;
    logic       uart1;
    logic       gpio;       // Only source that leaves hibernate
    logic [2:0] ttc;
    logic       dma;
    logic [3:0] macb_int;
  } irq_src_t;

endpackage

/* src/ahb_apb_bridge.sv */
`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                              i_hclk,
  input  logic                              i_reset,
  input  apb_subsys_pkg::ahb_req_t          i_ahb,
  output apb_subsys_pkg::ahb_rsp_t          o_ahb,
  output apb_subsys_pkg::apb_req_t          o_apb,     // pstrb left clear
  output logic [apb_subsys_pkg::SLOT_W-1:0] o_slot,
  output logic                              o_mapped,
  output logic                              o_active,  // Setup or access phase
  input  apb_subsys_pkg::apb_rsp_t          i_rsp      // Selected slot
);
  import apb_subsys_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,    // Also the data phase end of a good transfer
    S_SETUP,
    S_ACCESS,
    S_ERR1,    // ERROR, hready low
    S_ERR2     // ERROR, hready high
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic [31:0]       offs;
  logic              in_window;
  logic              hit;
  logic              trans_valid;
  logic              hready;
  logic              accept;
  logic [SLOT_W-1:0] slot_d;
  logic [SLOT_W-1:0] slot_q;
  logic              mapped_q;
  logic              write_q;
  logic [31:0]       addr_q;
  logic [31:0]       wdata_q;
  logic [31:0]       rdata_q;

  // ----------------------------------------
  // Address phase decode
  // ----------------------------------------
  assign offs      = i_ahb.haddr - SLOT_BASE;               // Wraps below base
  assign in_window = (offs[31:SLOT_SHIFT] < N_SLOTS);
  assign slot_d    = offs[SLOT_SHIFT +: SLOT_W];
  assign hit       = in_window && SLOT_USED[slot_d];        // Holes give ERROR

  assign trans_valid = (i_ahb.htrans == HTRANS_NONSEQ) || (i_ahb.htrans == HTRANS_SEQ);
  assign hready      = (state_q == S_IDLE) || (state_q == S_ERR2);
  assign accept      = i_ahb.hsel && hready && trans_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE, S_ERR2: begin
        if (accept) begin
          state_d = hit ? S_SETUP : S_ERR1;
        end else begin
          state_d = S_IDLE;
        end
      end
      S_SETUP:  state_d = S_ACCESS;
      S_ACCESS: state_d = i_rsp.pready ? S_IDLE : S_ACCESS;   // Stretch on wait states
      S_ERR1:   state_d = S_ERR2;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      state_q  <= S_IDLE;
      mapped_q <= 1'b0;
      slot_q   <= '0;
      write_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        mapped_q <= hit;
        slot_q   <= slot_d;
        write_q  <= i_ahb.hwrite;
      end
    end
  end

  // Address, write and read data
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q <= i_ahb.haddr;
    end
    if (state_q == S_SETUP) begin
      wdata_q <= i_ahb.hwdata;   // AHB data phase lines up with setup
    end
    if ((state_q == S_ACCESS) && i_rsp.pready) begin
      rdata_q <= i_rsp.prdata;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign o_active = (state_q == S_SETUP) || (state_q == S_ACCESS);
  assign o_slot   = slot_q;
  assign o_mapped = mapped_q;

  always_comb begin
    o_apb.paddr   = addr_q;
    o_apb.pwrite  = write_q;
    o_apb.pwdata  = (state_q == S_SETUP) ? i_ahb.hwdata : wdata_q;  // Bypass in setup
    o_apb.pstrb   = '0;
    o_apb.penable = (state_q == S_ACCESS);
  end

  assign o_ahb.hrdata = rdata_q;
  assign o_ahb.hready = hready;
  assign o_ahb.hresp  = ((state_q == S_ERR1) || (state_q == S_ERR2)) ? HRESP_ERROR
                                                                      : HRESP_OKAY;

  // Access phase always follows a setup cycle of the same transfer
  a_penable_after_setup: assert property (@(posedge i_hclk) disable iff (i_reset)
    o_apb.penable |-> (o_active && $past(o_active)));

  // Accepted transfer stalls the AHB side next cycle
  a_stall_after_accept: assert property (@(posedge i_hclk) disable iff (i_reset)
    accept |=> !o_ahb.hready);

endmodule

/* src/apb_slot_decoder.sv */
`timescale 1ns/1ps

module apb_slot_decoder #(
  parameter int BIG_ENDIAN = 0   // 1 swaps UART byte lanes
) (
  input  apb_subsys_pkg::apb_req_t           i_apb,
  input  logic [apb_subsys_pkg::SLOT_W-1:0]  i_slot,
  input  logic                               i_mapped,
  input  logic                               i_active,
  output apb_subsys_pkg::apb_req_t           o_apb,       // With byte strobes
  output logic [apb_subsys_pkg::N_SLOTS-1:0] o_psel,
  input  apb_subsys_pkg::apb_rsp_t           i_slot_rsp [apb_subsys_pkg::N_SLOTS],
  input  apb_subsys_pkg::apb_rsp_t           i_pmc_rsp,   // Internal slot
  output apb_subsys_pkg::apb_rsp_t           o_rsp
);
  import apb_subsys_pkg::*;

  // Answer of a hole, ready at once with no data
  localparam apb_rsp_t RSP_EMPTY = '{prdata: 32'h0, pready: 1'b1};

  logic [1:0] lane;
  logic       byte_slot;
  apb_rsp_t   slot_rsp [N_SLOTS];

  // ----------------------------------------
  // Peripheral select
  // ----------------------------------------
  always_comb begin
    o_psel = '0;
    if (i_mapped && i_active) begin
      o_psel[i_slot] = 1'b1;   // Bridge only marks valid slots
    end
  end

  // ----------------------------------------
  // Byte lanes for the UARTs
  // ----------------------------------------
  // UART registers sit on byte addresses, so only one lane is live
  assign lane      = (BIG_ENDIAN != 0) ? ~i_apb.paddr[1:0] : i_apb.paddr[1:0];
  assign byte_slot = (i_slot == SLOT_UART0) || (i_slot == SLOT_UART1);

  always_comb begin
    o_apb       = i_apb;
    o_apb.pstrb = byte_slot ? (4'b0001 << lane) : 4'b1111;   // Word slots get all lanes
  end

  // ----------------------------------------
  // Response mux
  // ----------------------------------------
  for (genvar s = 0; s < N_SLOTS; s++) begin : g_rsp
    if (s == SLOT_PMC) begin : g_pmc
      assign slot_rsp[s] = i_pmc_rsp;
    end else if (SLOT_USED[s]) begin : g_ext
      assign slot_rsp[s] = i_slot_rsp[s];
    end else begin : g_hole
      assign slot_rsp[s] = RSP_EMPTY;   // External entry ignored
    end
  end

  assign o_rsp = (i_slot < N_SLOTS) ? slot_rsp[i_slot] : RSP_EMPTY;

  // At most one slot selected
  a_psel_onehot: assert final ($onehot0(o_psel));

endmodule

/* src/power_ctrl.sv */
`timescale 1ns/1ps

module power_ctrl #(
  parameter int N_MACB = 4
) (
  input  logic                                 i_hclk,
  input  logic                                 i_reset,
  input  apb_subsys_pkg::apb_req_t             i_apb,
  input  logic                                 i_psel,
  output apb_subsys_pkg::apb_rsp_t             o_rsp,
  input  apb_subsys_pkg::irq_src_t             i_irq,
  input  logic [N_MACB-1:0]                    i_macb_wakeup,
  output logic [apb_subsys_pkg::N_DOMAINS-1:0] o_clk_en,
  output logic                                 o_pcm_irq    // MAC wake pending
);
  import apb_subsys_pkg::*;

  logic [N_DOMAINS-1:0]  gate_q;     // 1 stops the domain clock
  logic [N_DOMAINS-1:0]  gate_d;
  logic                  iso_q;      // isolate_mem, hibernate
  logic                  iso_d;
  logic [N_MACB-1:0]     wake_q;     // Sticky WAKE_STATUS
  logic [N_MACB-1:0]     wake_clr;
  logic [N_DOMAINS-1:0]  clk_en_q;
  logic [SLOT_SHIFT-1:0] reg_off;
  logic                  wr_acc;
  logic                  wr_ctrl;
  logic                  wr_wake;
  logic                  wake;

  // MAC domains must fill the top of the domain map
  if (N_MACB != N_DOMAINS - DOM_MACB0) begin : g_bad_macb
    $error("power_ctrl: N_MACB does not fit the power domain map");
  end

  // ----------------------------------------
  // APB write decode
  // ----------------------------------------
  assign reg_off = {i_apb.paddr[SLOT_SHIFT-1:2], 2'b00};   // Word aligned
  assign wr_acc  = i_psel && i_apb.penable && i_apb.pwrite;  // Access edge, no waits
  assign wr_ctrl = wr_acc && (reg_off == PMC_CTRL_OFFS);
  assign wr_wake = wr_acc && (reg_off == PMC_WAKE_OFFS);

  // Write one to clear
  assign wake_clr = (wr_wake && i_apb.pstrb[0]) ? i_apb.pwdata[N_MACB-1:0] : '0;

  // ----------------------------------------
  // Wake detection
  // ----------------------------------------
  assign o_pcm_irq = |wake_q;

  // Sleep wakes on any event, hibernate only on GPIO
  assign wake = (((|i_irq) || o_pcm_irq) && !iso_q) || (i_irq.gpio && iso_q);

  always_comb begin
    gate_d = gate_q;
    iso_d  = iso_q;
    if (wake) begin             // Wins over a CTRL write
      gate_d = '0;
      iso_d  = 1'b0;
    end else if (wr_ctrl) begin
      if (i_apb.pstrb[0]) begin
        gate_d = i_apb.pwdata[N_DOMAINS-1:0];
      end
      if (i_apb.pstrb[CTRL_ISO_BIT / 8]) begin
        iso_d = i_apb.pwdata[CTRL_ISO_BIT];
      end
    end
  end

  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      gate_q   <= '0;
      iso_q    <= 1'b0;
      clk_en_q <= '1;          // All domains clocked
      wake_q   <= '0;
    end else begin
      gate_q   <= gate_d;
      iso_q    <= iso_d;
      clk_en_q <= ~gate_d;     // Enable tracks the gate bit edge for edge
      wake_q   <= (wake_q & ~wake_clr) | i_macb_wakeup;   // New wake-up beats clear
    end
  end

  assign o_clk_en = clk_en_q;

  // ----------------------------------------
  // Read back
  // ----------------------------------------
  always_comb begin
    o_rsp.prdata = '0;
    o_rsp.pready = 1'b1;   // Never waits
    case (reg_off)
      PMC_CTRL_OFFS: begin
        o_rsp.prdata[N_DOMAINS-1:0] = gate_q;
        o_rsp.prdata[CTRL_ISO_BIT]  = iso_q;
      end
      PMC_WAKE_OFFS: o_rsp.prdata[N_MACB-1:0] = wake_q;
      default: o_rsp.prdata = '0;   // Unused offsets
    endcase
  end

  // Every domain runs again the cycle after a wake event
  a_wake_clocks_on: assert property (@(posedge i_hclk) disable iff (i_reset)
    wake |=> (&o_clk_en));

endmodule

/* src/apb_subsystem.sv */
`timescale 1ns/1ps

module apb_subsystem #(
  parameter int BIG_ENDIAN = 0,
  parameter int N_MACB     = 4
) (
  input  logic                                 i_hclk,      // AHB and APB clock
  input  logic                                 i_reset,
  input  apb_subsys_pkg::ahb_req_t             i_ahb,
  output apb_subsys_pkg::ahb_rsp_t             o_ahb,
  output apb_subsys_pkg::apb_req_t             o_apb,       // To every slot
  output logic [apb_subsys_pkg::N_SLOTS-1:0]   o_psel,
  input  apb_subsys_pkg::apb_rsp_t             i_slot_rsp [apb_subsys_pkg::N_SLOTS],
  input  apb_subsys_pkg::irq_src_t             i_irq,
  input  logic [N_MACB-1:0]                    i_macb_wakeup,
  output logic [apb_subsys_pkg::N_DOMAINS-1:0] o_clk_en,
  output logic                                 o_pcm_irq
);
  import apb_subsys_pkg::*;

  apb_req_t          bridge_apb;   // Before strobes
  logic [SLOT_W-1:0] slot;
  logic              mapped;
  logic              active;
  apb_rsp_t          sel_rsp;
  apb_rsp_t          pmc_rsp;

  // ----------------------------------------
  // AHB to APB
  // ----------------------------------------
  ahb_apb_bridge u_bridge (
    .i_hclk   (i_hclk),
    .i_reset  (i_reset),
    .i_ahb    (i_ahb),
    .o_ahb    (o_ahb),
    .o_apb    (bridge_apb),
    .o_slot   (slot),
    .o_mapped (mapped),
    .o_active (active),
    .i_rsp    (sel_rsp)
  );

  apb_slot_decoder #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_decoder (
    .i_apb      (bridge_apb),
    .i_slot     (slot),
    .i_mapped   (mapped),
    .i_active   (active),
    .o_apb      (o_apb),
    .o_psel     (o_psel),
    .i_slot_rsp (i_slot_rsp),
    .i_pmc_rsp  (pmc_rsp),
    .o_rsp      (sel_rsp)
  );

  // Power control sits on its own slot
  power_ctrl #(
    .N_MACB (N_MACB)
  ) u_power_ctrl (
    .i_hclk        (i_hclk),
    .i_reset       (i_reset),
    .i_apb         (o_apb),
    .i_psel        (o_psel[SLOT_PMC]),
    .o_rsp         (pmc_rsp),
    .i_irq         (i_irq),
    .i_macb_wakeup (i_macb_wakeup),
    .o_clk_en      (o_clk_en),
    .o_pcm_irq     (o_pcm_irq)
  );

endmodule

/* tb/tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem;
  import apb_subsys_pkg::*;

  localparam int          BIG_ENDIAN = 0;
  localparam int          N_MACB     = 4;
  localparam int          XFER_LIMIT = 16;      // hready low cycles per transfer
  localparam int          RUN_LIMIT  = 20000;   // Whole run, in clock cycles
  localparam logic [31:0] PMC_CTRL   = SLOT_BASE + (32'(SLOT_PMC) << SLOT_SHIFT);
  localparam logic [31:0] PMC_WAKE   = PMC_CTRL + 32'h4;

  logic                 clk;
  logic                 reset;
  ahb_req_t             ahb_req;
  ahb_rsp_t             ahb_rsp;
  apb_req_t             apb_req;
  logic [N_SLOTS-1:0]   psel;
  apb_rsp_t             slot_rsp [N_SLOTS] = '{default: '0};
  irq_src_t             irq;
  logic [N_MACB-1:0]    macb_wakeup;
  logic [N_DOMAINS-1:0] clk_en;
  logic                 pcm_irq;

  logic [31:0] slot_mem [N_SLOTS][16];   // Inside the peripheral models
  logic [31:0] ref_mem  [N_SLOTS][16];   // Expected contents
  logic [3:0]  ref_wake;                 // Expected WAKE_STATUS
  int unsigned wait_left = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          test_no = 0;
  int          tests_failed = 0;
  logic        stuck = 1'b0;             // Set by a transfer that never ends
  string       stuck_msg;
  int          ext_slots [6] = '{SLOT_SPI, SLOT_UART0, SLOT_GPIO, SLOT_TTC, SLOT_SMC, SLOT_UART1};

  apb_subsystem #(
    .BIG_ENDIAN (BIG_ENDIAN),
    .N_MACB     (N_MACB)
  ) uut (
    .i_hclk        (clk),
    .i_reset       (reset),
    .i_ahb         (ahb_req),
    .o_ahb         (ahb_rsp),
    .o_apb         (apb_req),
    .o_psel        (psel),
    .i_slot_rsp    (slot_rsp),
    .i_irq         (irq),
    .i_macb_wakeup (macb_wakeup),
    .o_clk_en      (clk_en),
    .o_pcm_irq     (pcm_irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  // UARTs are byte wide, one live lane
  function automatic logic [3:0] lane_strobe(input int slot, input logic [1:0] off);
    if (slot == SLOT_UART0 || slot == SLOT_UART1) begin
      return 4'b0001 << ((BIG_ENDIAN != 0) ? 2'd3 - off : off);
    end
    return 4'b1111;
  endfunction

  function automatic irq_src_t random_irq(input logic allow_gpio);
    irq_src_t v;
    v = irq_src_t'(12'(1) << ($urandom % 12));   // One source
    if (!allow_gpio && v.gpio) begin
      v.gpio = 1'b0;
      v.dma  = 1'b1;
    end
    return v;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    test_no++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: passed", test_no, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", test_no, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // ----------------------------------------
  // APB peripheral models, 0 to 3 wait states
  // ----------------------------------------
  always @(negedge clk) begin : periph_models
    int         sel;
    logic [3:0] idx;
    sel = -1;
    for (int k = 0; k < N_SLOTS; k++) begin
      slot_rsp[k] = '0;
      if (psel[k]) sel = k;
    end
    idx = apb_req.paddr[5:2];
    if (sel >= 0 && sel != SLOT_PMC) begin
      if (!apb_req.penable) begin
        wait_left = $urandom % 4;   // Setup cycle
      end else if (wait_left != 0) begin
        wait_left--;
      end else begin
        slot_rsp[sel].pready = 1'b1;
        slot_rsp[sel].prdata = slot_mem[sel][idx];
        if (apb_req.pwrite) begin
          slot_mem[sel][idx] = merge_lanes(slot_mem[sel][idx], apb_req.pwdata, apb_req.pstrb);
        end
      end
    end
  end

  // One AHB transfer, address phase then data phase until hready
  task automatic bus_transfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic resp,
                              output logic resp_low, output int low,
                              output logic [N_SLOTS-1:0] psel_seen, output logic [3:0] strb_seen);
    @(negedge clk);
    ahb_req.hsel   = 1'b1;
    ahb_req.haddr  = addr;
    ahb_req.htrans = HTRANS_NONSEQ;
    ahb_req.hwrite = wr;
    ahb_req.hsize  = (addr[1:0] != 2'b00) ? 3'b000 : 3'b010;   // Byte or word
    @(negedge clk);                                          // Accepted at the edge
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = 2'b00;
    ahb_req.hwdata = wdata;
    low       = 0;
    resp_low  = 1'bx;
    psel_seen = '0;
    strb_seen = '0;
    while (!ahb_rsp.hready) begin
      if (low == 0) resp_low = ahb_rsp.hresp;   // First stalled cycle
      if (psel != '0) begin
        psel_seen |= psel;
        strb_seen = apb_req.pstrb;
      end
      low++;
      if (low > XFER_LIMIT) begin
        stuck_msg = $sformatf("Timeout, hready stayed low for %0d cycles at address %h",
                              low, addr);
        stuck = 1'b1;
        forever @(negedge clk);   // Watchdog ends the run
      end
      @(negedge clk);
    end
    rdata = ahb_rsp.hrdata;
    resp  = ahb_rsp.hresp;
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (!stuck && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (stuck) begin
      $display("%s", stuck_msg);
    end else begin
      $display("Run did not finish within %0d clock cycles", RUN_LIMIT);
    end
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Random access to one external slot, checked against ref_mem
  task automatic access_slot(input int slot);
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;
    logic [31:0]        exp_data;
    logic               wr;
    logic               resp;
    logic               resp_low;
    int                 low;
    logic [3:0]         idx;
    logic [1:0]         off;
    logic [3:0]         exp_strb;
    logic [3:0]         strb_seen;
    logic [N_SLOTS-1:0] psel_seen;
    logic [N_SLOTS-1:0] exp_psel;
    wr    = 1'($urandom % 2);
    idx   = 4'($urandom % 16);
    off   = 2'($urandom % 4);
    wdata = $urandom;
    addr  = SLOT_BASE + (32'(slot) << SLOT_SHIFT) + (32'(idx) << 2) + 32'(off);
    exp_strb = lane_strobe(slot, off);
    exp_psel = '0;
    exp_psel[slot] = 1'b1;
    exp_data = ref_mem[slot][idx];
    bus_transfer(addr, wr, wdata, rdata, resp, resp_low, low, psel_seen, strb_seen);
    if (wr) ref_mem[slot][idx] = merge_lanes(exp_data, wdata, exp_strb);
    if (resp !== HRESP_OKAY || resp_low !== HRESP_OKAY) begin
      flag_error($sformatf("Response %b then %b at %h, expected OKAY", resp_low, resp, addr));
    end
    if (low < 2 || low > 5) flag_error($sformatf("Latency %0d cycles at %h", low, addr));
    if (psel_seen !== exp_psel) begin
      flag_error($sformatf("psel %b at %h, expected %b", psel_seen, addr, exp_psel));
    end
    if (strb_seen !== exp_strb) begin
      flag_error($sformatf("pstrb %b at %h, expected %b", strb_seen, addr, exp_strb));
    end
    if (!wr && rdata !== exp_data) begin
      flag_error($sformatf("Read %h at %h, expected %h", rdata, addr, exp_data));
    end
  endtask

  // Holes at slots 4 and 7, and addresses outside the window
  task automatic access_hole();
    logic [31:0]        addr;
    logic [31:0]        rdata;
    logic               resp;
    logic               resp_low;
    int                 low;
    logic [3:0]         strb_seen;
    logic [N_SLOTS-1:0] psel_seen;
    case ($urandom % 4)
      0:       addr = SLOT_BASE + (32'd4 << SLOT_SHIFT) + ($urandom % 32'h1_0000);
      1:       addr = SLOT_BASE + (32'd7 << SLOT_SHIFT) + ($urandom % 32'h1_0000);
      2:       addr = $urandom % SLOT_BASE;                       // Below the window
      default: addr = SLOT_BASE + (32'd9 << SLOT_SHIFT) + ($urandom % 32'h1000_0000);
    endcase
    bus_transfer(addr, 1'($urandom % 2), $urandom, rdata, resp, resp_low, low,
                 psel_seen, strb_seen);
    if (resp !== HRESP_ERROR || resp_low !== HRESP_ERROR) begin
      flag_error($sformatf("Response %b then %b at unmapped %h", resp_low, resp, addr));
    end
    if (low != 1) flag_error($sformatf("Error response took %0d low cycles at %h", low, addr));
    if (psel_seen !== '0) flag_error($sformatf("psel %b raised for %h", psel_seen, addr));
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0]        rdata;
    logic               resp;
    logic               resp_low;
    int                 low;
    logic [3:0]         st;
    logic [N_SLOTS-1:0] ps;
    bus_transfer(addr, 1'b1, data, rdata, resp, resp_low, low, ps, st);
    if (resp !== HRESP_OKAY) flag_error($sformatf("ERROR response on write to %h", addr));
  endtask

  task automatic expect_reg(input logic [31:0] addr, input logic [31:0] exp, input string what);
    logic [31:0]        rdata;
    logic               resp;
    logic               resp_low;
    int                 low;
    logic [3:0]         st;
    logic [N_SLOTS-1:0] ps;
    bus_transfer(addr, 1'b0, 32'h0, rdata, resp, resp_low, low, ps, st);
    if (resp !== HRESP_OKAY || rdata !== exp) begin
      flag_error($sformatf("%s read %h resp %0d, expected %h", what, rdata, resp, exp));
    end
  endtask

  task automatic pulse_irq(input irq_src_t v);
    @(negedge clk) irq = v;
    @(negedge clk) irq = '0;
  endtask

  task automatic pulse_wakeup(input logic [N_MACB-1:0] v);
    @(negedge clk) macb_wakeup = v;
    @(negedge clk) macb_wakeup = '0;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    logic [5:0] g;
    logic [3:0] w;
    logic [3:0] c;
    irq_src_t   iv;
    void'($urandom(473));
    reset       = 1'b1;
    ahb_req     = '0;
    irq         = '0;
    macb_wakeup = '0;
    for (int s = 0; s < N_SLOTS; s++) begin
      for (int i = 0; i < 16; i++) begin
        slot_mem[s][i] = 32'(s * 16 + i) * 32'h9E37_79B1;   // Hash of the word address
        ref_mem[s][i]  = slot_mem[s][i];
      end
    end
    repeat (10) @(posedge clk);
    @(negedge clk) reset = 1'b0;

    if (ahb_rsp.hready !== 1'b1 || ahb_rsp.hresp !== HRESP_OKAY) begin
      flag_error("AHB response after reset");
    end
    if (psel !== '0 || apb_req.penable !== 1'b0) flag_error("APB select after reset");
    if (clk_en !== '1 || pcm_irq !== 1'b0) flag_error("Power outputs after reset");
    end_test("reset values");

    repeat (150) access_slot(ext_slots[$urandom % 6]);
    end_test("read-back");

    repeat (80) access_slot(($urandom % 2) ? ext_slots[$urandom % 6]
                                           : (($urandom % 2) ? SLOT_UART0 : SLOT_UART1));
    end_test("byte lanes");

    repeat (40) access_hole();
    end_test("unmapped slots");

    g = 6'($urandom % 63 + 1);
    write_reg(PMC_CTRL, 32'(g));
    if (clk_en !== ~g) flag_error($sformatf("clk_en %b after gating %b", clk_en, g));
    expect_reg(PMC_CTRL, 32'(g), "CTRL");
    pulse_irq(random_irq(1'b1));
    if (clk_en !== '1) flag_error($sformatf("clk_en %b after wake", clk_en));
    expect_reg(PMC_CTRL, 32'h0, "CTRL after wake");
    end_test("gating");

    g = 6'($urandom % 63 + 1);
    write_reg(PMC_CTRL, 32'h100 | 32'(g));   // isolate_mem plus gates
    expect_reg(PMC_CTRL, 32'h100 | 32'(g), "CTRL in hibernate");
    pulse_irq(random_irq(1'b0));
    expect_reg(PMC_CTRL, 32'h100 | 32'(g), "CTRL after non-GPIO irq");
    if (clk_en !== ~g) flag_error($sformatf("clk_en %b in hibernate", clk_en));
    iv      = '0;
    iv.gpio = 1'b1;
    pulse_irq(iv);
    if (clk_en !== '1) flag_error($sformatf("clk_en %b after GPIO wake", clk_en));
    expect_reg(PMC_CTRL, 32'h0, "CTRL after GPIO wake");
    end_test("hibernate");

    w = 4'($urandom % 15 + 1);
    pulse_wakeup(w);
    ref_wake = w;
    w = 4'($urandom % 15 + 1);
    pulse_wakeup(w);
    ref_wake |= w;
    if (pcm_irq !== 1'b1) flag_error("pcm_irq low with wake-ups pending");
    expect_reg(PMC_WAKE, 32'(ref_wake), "WAKE_STATUS");
    c = ref_wake & (~ref_wake + 4'd1);       // Lowest pending bit
    write_reg(PMC_WAKE, 32'(c));
    ref_wake &= ~c;
    expect_reg(PMC_WAKE, 32'(ref_wake), "WAKE_STATUS after partial clear");
    if (pcm_irq !== (|ref_wake)) flag_error($sformatf("pcm_irq %b after partial clear", pcm_irq));
    write_reg(PMC_WAKE, 32'hF);
    expect_reg(PMC_WAKE, 32'h0, "WAKE_STATUS after full clear");
    if (pcm_irq !== 1'b0) flag_error("pcm_irq still high after full clear");
    end_test("MAC wake-ups");

    $display("Summary: %0d tests, %0d failed, %0d errors", test_no, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* apb_subsystem.f */
src/apb_subsys_pkg.sv
src/ahb_apb_bridge.sv
src/apb_slot_decoder.sv
src/power_ctrl.sv
src/apb_subsystem.sv
tb/tb_apb_subsystem.sv

/* Bender.yml */
package:
  name: apb_subsystem

sources:
  - files:
      - src/apb_subsys_pkg.sv
      - src/ahb_apb_bridge.sv
      - src/apb_slot_decoder.sv
      - src/power_ctrl.sv
      - src/apb_subsystem.sv
  - target: simulation
    files:
      - tb/tb_apb_subsystem.sv
